/* Makefile */
TOP = bp_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o bp_sim
	./obj_dir/bp_sim

clean:
	rm -rf obj_dir

/* logic/bp_lookup_stage.sv */
// Lookup stage
// Takes credited fetch requests, reads the table and forms the prediction

`timescale 1ns/10ps

module bp_lookup_stage (
    input  logic                         clk,
    input  logic                         pon_rst_n_i,
    input  logic                         req_valid_i,
    input  logic [bp_pkg::ADDR_W-1:0]    req_pc_i,
    output logic [bp_pkg::IDX_W-1:0]     rd_idx_o,
    output logic                         rd_en_o,
    input  logic [bp_pkg::CNT_W-1:0]     rd_cnt_i,
    input  logic [bp_pkg::ADDR_W-1:0]    rd_target_i,
    output logic                         pred_valid_o,
    output bp_pkg::pred_t                pred_o
);

    logic                      s1_valid;
    logic [bp_pkg::ADDR_W-1:0] s1_pc;

    // Table index is the low address bits, read issued on accept
    assign rd_idx_o = req_pc_i[bp_pkg::IDX_W-1:0];
    assign rd_en_o  = req_valid_i;

    // Stage 1 holds the request while the table read completes
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            s1_pc <= req_pc_i;
        end
    end

    // Stage 2 valid
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            pred_valid_o <= 1'b0;
        end else begin
            pred_valid_o <= s1_valid;
        end
    end

    // Direction comes from the counter's upper bit
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            pred_o.taken  <= rd_cnt_i[bp_pkg::CNT_W-1];
            pred_o.target <= rd_target_i;
            pred_o.pc     <= s1_pc;
            pred_o.cnt    <= rd_cnt_i;
        end
    end

endmodule

/* logic/bp_outcome_queue.sv */
// Outcome queue
// In-order buffer of predictions awaiting execution, one credit back per pop

`timescale 1ns/10ps

module bp_outcome_queue (
    input  logic              clk,
    input  logic              pon_rst_n_i,
    input  logic              push_i,
    input  bp_pkg::pred_t     push_data_i,
    input  logic              pop_i,
    output bp_pkg::pred_t     head_o,
    output logic              credit_o
);

    bp_pkg::pred_t             mem [bp_pkg::QUEUE_DEPTH];
    logic [bp_pkg::QPTR_W-1:0] wr_ptr;
    logic [bp_pkg::QPTR_W-1:0] rd_ptr;

    // Pointers wrap at the power-of-two depth
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + bp_pkg::QPTR_W'(1);
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + bp_pkg::QPTR_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // Oldest prediction, popped in the cycle its outcome arrives
    assign head_o = mem[rd_ptr];

    // Freed slot goes straight back to fetch
    assign credit_o = pop_i;

endmodule

/* logic/bp_pkg.sv */
// Branch predictor shared definitions
// Address and table widths, queue depth and the structs passed between stages

package bp_pkg;

    // Instruction address and table geometry
    localparam int ADDR_W      = 13;
    localparam int IDX_W       = 8;
    localparam int TABLE_DEPTH = 256;
    localparam int CNT_W       = 2;

    // Outstanding predictions, also the credit count after reset
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

    // Weakly not taken
    localparam logic [CNT_W-1:0] CNT_RESET = 2'b01;

    // Prediction as produced by the lookup stage
    typedef struct packed {
        logic              taken;
        logic [ADDR_W-1:0] target;
        logic [ADDR_W-1:0] pc;
        logic [CNT_W-1:0]  cnt;
    } pred_t;

    // Resolved branch from execution
    typedef struct packed {
        logic              taken;
        logic [ADDR_W-1:0] target;
    } outcome_t;

    // Table update from the resolve stage
    typedef struct packed {
        logic [IDX_W-1:0]  idx;
        logic [CNT_W-1:0]  cnt;
        logic [ADDR_W-1:0] target;
        logic              wr_target;
    } tbl_wr_t;

endpackage

/* logic/bp_pred_table.sv */
// Prediction table
// Holds a 2-bit counter and a branch target per entry, registered read port

`timescale 1ns/10ps

module bp_pred_table (
    input  logic                         clk,
    input  logic                         pon_rst_n_i,
    input  logic [bp_pkg::IDX_W-1:0]     rd_idx_i,
    input  logic                         rd_en_i,
    output logic [bp_pkg::CNT_W-1:0]     rd_cnt_o,
    output logic [bp_pkg::ADDR_W-1:0]    rd_target_o,
    input  logic                         wr_valid_i,
    input  bp_pkg::tbl_wr_t              wr_i
);

    logic [bp_pkg::CNT_W-1:0]  cnt_mem [bp_pkg::TABLE_DEPTH];
    logic [bp_pkg::ADDR_W-1:0] tgt_mem [bp_pkg::TABLE_DEPTH];

    // Counter array, every entry starts weakly not taken
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            for (int i = 0; i < bp_pkg::TABLE_DEPTH; i++) begin
                cnt_mem[i] <= bp_pkg::CNT_RESET;
            end
        end else if (wr_valid_i) begin
            cnt_mem[wr_i.idx] <= wr_i.cnt;
        end
    end

    // Target array, only taken branches overwrite the target
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            for (int i = 0; i < bp_pkg::TABLE_DEPTH; i++) begin
                tgt_mem[i] <= '0;
            end
        end else if (wr_valid_i && wr_i.wr_target) begin
            tgt_mem[wr_i.idx] <= wr_i.target;
        end
    end

    // Registered read
    // a write to the same index in the same cycle is not seen here
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_cnt_o    <= cnt_mem[rd_idx_i];
            rd_target_o <= tgt_mem[rd_idx_i];
        end
    end

endmodule

/* logic/bp_resolve_stage.sv */
// Resolve stage
// Checks each outcome against the oldest prediction and builds the table update

`timescale 1ns/10ps

module bp_resolve_stage (
    input  logic              clk,
    input  logic              pon_rst_n_i,
    input  logic              res_valid_i,
    input  bp_pkg::outcome_t  res_i,
    input  bp_pkg::pred_t     head_i,
    output logic              pop_o,
    output logic              upd_valid_o,
    output logic              upd_correct_o,
    output logic              wr_valid_o,
    output bp_pkg::tbl_wr_t   wr_o
);

    logic [bp_pkg::IDX_W-1:0] head_idx;
    logic [bp_pkg::CNT_W-1:0] base_cnt;
    logic [bp_pkg::CNT_W-1:0] next_cnt;
    logic                     correct;
    logic                     wr_seen;

    assign pop_o    = res_valid_i;
    assign head_idx = head_i.pc[bp_pkg::IDX_W-1:0];

    // Last write still holds the table's value for its index,
    // which may be newer than the counter captured at prediction time
    assign base_cnt = (wr_seen && (wr_o.idx == head_idx)) ? wr_o.cnt : head_i.cnt;

    // Saturating 2-bit counter
    always_comb begin
        next_cnt = base_cnt;
        if (res_i.taken) begin
            if (base_cnt != '1) begin
                next_cnt = base_cnt + bp_pkg::CNT_W'(1);
            end
        end else if (base_cnt != '0) begin
            next_cnt = base_cnt - bp_pkg::CNT_W'(1);
        end
    end

    // Target only matters when the branch was actually taken
    assign correct = (head_i.taken == res_i.taken) &&
                     (!res_i.taken || (head_i.target == res_i.target));

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            upd_valid_o   <= 1'b0;
            upd_correct_o <= 1'b0;
            wr_valid_o    <= 1'b0;
            wr_seen       <= 1'b0;
        end else begin
            upd_valid_o <= res_valid_i;
            wr_valid_o  <= res_valid_i;
            if (res_valid_i) begin
                upd_correct_o <= correct;
                wr_seen       <= 1'b1;
            end
        end
    end

    // Table write, held until the next outcome
    always_ff @(posedge clk) begin
        if (res_valid_i) begin
            wr_o.idx       <= head_idx;
            wr_o.cnt       <= next_cnt;
            wr_o.target    <= res_i.target;
            wr_o.wr_target <= res_i.taken;
        end
    end

endmodule

/* logic/bp_top.sv */
// Branch predictor top
// Lookup, table, outcome queue and resolve stage with credit-based flow control

`timescale 1ns/10ps

module bp_top (
    input  logic                         clk,
    input  logic                         pon_rst_n_i,
    input  logic                         req_valid_i,
    input  logic [bp_pkg::ADDR_W-1:0]    req_pc_i,
    output logic                         pred_valid_o,
    output bp_pkg::pred_t                pred_o,
    input  logic                         res_valid_i,
    input  bp_pkg::outcome_t             res_i,
    output logic                         upd_valid_o,
    output logic                         upd_correct_o,
    output logic                         credit_o
);

    logic [bp_pkg::IDX_W-1:0]  rd_idx;
    logic                      rd_en;
    logic [bp_pkg::CNT_W-1:0]  rd_cnt;
    logic [bp_pkg::ADDR_W-1:0] rd_target;
    logic                      wr_valid;
    bp_pkg::tbl_wr_t           wr;
    bp_pkg::pred_t             head;
    logic                      pop;

    bp_lookup_stage i_bp_lookup_stage (
        .clk          (clk),
        .pon_rst_n_i  (pon_rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_pc_i     (req_pc_i),
        .rd_idx_o     (rd_idx),
        .rd_en_o      (rd_en),
        .rd_cnt_i     (rd_cnt),
        .rd_target_i  (rd_target),
        .pred_valid_o (pred_valid_o),
        .pred_o       (pred_o)
    );

    bp_pred_table i_bp_pred_table (
        .clk          (clk),
        .pon_rst_n_i  (pon_rst_n_i),
        .rd_idx_i     (rd_idx),
        .rd_en_i      (rd_en),
        .rd_cnt_o     (rd_cnt),
        .rd_target_o  (rd_target),
        .wr_valid_i   (wr_valid),
        .wr_i         (wr)
    );

    // Every shown prediction is queued until its outcome
    bp_outcome_queue i_bp_outcome_queue (
        .clk          (clk),
        .pon_rst_n_i  (pon_rst_n_i),
        .push_i       (pred_valid_o),
        .push_data_i  (pred_o),
        .pop_i        (pop),
        .head_o       (head),
        .credit_o     (credit_o)
    );

    bp_resolve_stage i_bp_resolve_stage (
        .clk           (clk),
        .pon_rst_n_i   (pon_rst_n_i),
        .res_valid_i   (res_valid_i),
        .res_i         (res_i),
        .head_i        (head),
        .pop_o         (pop),
        .upd_valid_o   (upd_valid_o),
        .upd_correct_o (upd_correct_o),
        .wr_valid_o    (wr_valid),
        .wr_o          (wr)
    );

endmodule

/* tests/bp_tb.sv */
// Branch predictor testbench
// Table-driven requests and outcomes checked against a reference model of the predictor

`timescale 1ns/10ps

module bp_tb;

    typedef enum logic [1:0] {K_REQ, K_RES, K_CRED} step_kind_e;

    typedef struct packed {
        step_kind_e                kind;
        logic [bp_pkg::ADDR_W-1:0] pc;
        logic                      taken;
        logic [bp_pkg::ADDR_W-1:0] target;
        logic [2:0]                credits;
    } step_t;

    // Prediction expected on the cycle in due
    typedef struct packed {
        logic [31:0]   due;
        bp_pkg::pred_t pred;
    } pend_t;

    logic                      clk;
    logic                      pon_rst_n_i;
    logic                      req_valid_i;
    logic [bp_pkg::ADDR_W-1:0] req_pc_i;
    logic                      pred_valid_o;
    bp_pkg::pred_t             pred_o;
    logic                      res_valid_i;
    bp_pkg::outcome_t          res_i;
    logic                      upd_valid_o;
    logic                      upd_correct_o;
    logic                      credit_o;

    // Reference model state
    logic [bp_pkg::CNT_W-1:0]  m_cnt [bp_pkg::TABLE_DEPTH];
    logic [bp_pkg::ADDR_W-1:0] m_tgt [bp_pkg::TABLE_DEPTH];
    pend_t                     pend_q[$];
    bp_pkg::pred_t             res_q[$];
    step_t                     steps[$];

    logic [31:0]   rng;
    int            cycles = 0;
    int            limit = 100000;
    int            credits;
    int            last_res_cyc;
    logic          last_res;
    logic          exp_correct;
    logic          shown_now;
    bp_pkg::pred_t shown_pred;

    bp_top i_bp_top (
        .clk           (clk),
        .pon_rst_n_i   (pon_rst_n_i),
        .req_valid_i   (req_valid_i),
        .req_pc_i      (req_pc_i),
        .pred_valid_o  (pred_valid_o),
        .pred_o        (pred_o),
        .res_valid_i   (res_valid_i),
        .res_i         (res_i),
        .upd_valid_o   (upd_valid_o),
        .upd_correct_o (upd_correct_o),
        .credit_o      (credit_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: %s expected %h got %h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_credits(input int exp);
        assert (credits == exp) else begin
            $display("testbench holds %0d credits where %0d were expected", credits, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic request_step(input logic [bp_pkg::ADDR_W-1:0] pc);
        steps.push_back(step_t'{K_REQ, pc, 1'b0, '0, 3'd0});
    endtask

    task automatic outcome_step(input logic taken, input logic [bp_pkg::ADDR_W-1:0] target);
        steps.push_back(step_t'{K_RES, '0, taken, target, 3'd0});
    endtask

    task automatic credit_step(input logic [2:0] n);
        steps.push_back(step_t'{K_CRED, '0, 1'b0, '0, n});
    endtask

    task automatic build_directed();
        // Counter climbs to strongly taken, then a taken branch to a new target
        request_step(13'h0a35);
        outcome_step(1'b1, 13'h0800);
        request_step(13'h0a35);
        outcome_step(1'b1, 13'h0800);
        request_step(13'h0a35);
        outcome_step(1'b1, 13'h0800);
        request_step(13'h0a35);
        outcome_step(1'b1, 13'h0c00);
        // Not taken down to 00, target must survive
        for (int i = 0; i < 4; i++) begin
            request_step(13'h0a35);
            outcome_step(1'b0, 13'h1fff);
        end
        request_step(13'h0a35);
        outcome_step(1'b1, 13'h0123);
        // Two in flight for one index, second update builds on the first
        request_step(13'h0055);
        request_step(13'h0055);
        outcome_step(1'b1, 13'h0321);
        outcome_step(1'b1, 13'h0321);
        request_step(13'h0055);
        outcome_step(1'b0, 13'h0000);
        // Full queue
        for (int i = 0; i < bp_pkg::QUEUE_DEPTH; i++) begin
            request_step(13'h0140 + 13'(i));
        end
        credit_step(3'd0);
        outcome_step(1'b1, 13'h0200);
        outcome_step(1'b0, 13'h0000);
        outcome_step(1'b1, 13'h0300);
        outcome_step(1'b1, 13'h0000);
        credit_step(3'(bp_pkg::QUEUE_DEPTH));
        // Reading back shows each update landed on its own index
        for (int i = 0; i < bp_pkg::QUEUE_DEPTH; i++) begin
            request_step(13'h0140 + 13'(i));
        end
        for (int i = 0; i < bp_pkg::QUEUE_DEPTH; i++) begin
            outcome_step(1'b1, 13'h0200);
        end
    endtask

    // Batches use distinct indices among 8 and resolve fully before the next
    task automatic build_random(input int min_steps);
        int         n;
        logic [2:0] base;
        logic [2:0] idx;
        while (steps.size() < min_steps) begin
            rng = xorshift32(rng);
            n = int'(rng[1:0]) + 1;
            base = rng[4:2];
            for (int j = 0; j < n; j++) begin
                rng = xorshift32(rng);
                idx = base + 3'(j);
                request_step({rng[12:8], 5'b0, idx});
            end
            for (int j = 0; j < n; j++) begin
                rng = xorshift32(rng);
                outcome_step(rng[0], {2'b10, rng[9:8], 9'h0f0});
            end
        end
    endtask

    task automatic issue_request(input logic [bp_pkg::ADDR_W-1:0] pc);
        pend_t            p;
        logic [bp_pkg::IDX_W-1:0] idx;
        idx = pc[bp_pkg::IDX_W-1:0];
        p.due = 32'(cycles + 2);
        p.pred.taken = m_cnt[idx][1];
        p.pred.target = m_tgt[idx];
        p.pred.pc = pc;
        p.pred.cnt = m_cnt[idx];
        pend_q.push_back(p);
        req_valid_i = 1'b1;
        req_pc_i = pc;
        credits--;
    endtask

    task automatic apply_outcome(input logic taken, input logic [bp_pkg::ADDR_W-1:0] target);
        bp_pkg::pred_t            head;
        logic [bp_pkg::IDX_W-1:0] idx;
        head = res_q.pop_front();
        idx = head.pc[bp_pkg::IDX_W-1:0];
        // A taken branch also needs the right target
        if (taken) begin
            exp_correct = head.taken && (head.target == target);
        end else begin
            exp_correct = !head.taken;
        end
        if (taken) begin
            if (m_cnt[idx] != 2'b11) begin
                m_cnt[idx] = m_cnt[idx] + 2'd1;
            end
            m_tgt[idx] = target;
        end else if (m_cnt[idx] != 2'b00) begin
            m_cnt[idx] = m_cnt[idx] - 2'd1;
        end
        res_valid_i = 1'b1;
        res_i.taken = taken;
        res_i.target = target;
        last_res = 1'b1;
        last_res_cyc = cycles;
    endtask

    // Outputs from the last rising edge, credit_o from the inputs still held
    task automatic check_outputs();
        pend_t p;
        shown_now = 1'b0;
        check_value("credit_o", 32'(credit_o), 32'(last_res));
        if (credit_o) begin
            credits++;
        end
        check_value("upd_valid_o", 32'(upd_valid_o), 32'(last_res));
        if (last_res) begin
            check_value("upd_correct_o", 32'(upd_correct_o), 32'(exp_correct));
        end
        if (pend_q.size() > 0 && pend_q[0].due == 32'(cycles)) begin
            p = pend_q.pop_front();
            check_value("pred_valid_o", 32'(pred_valid_o), 32'd1);
            check_value("pred_o", 32'(pred_o), 32'(p.pred));
            shown_pred = p.pred;
            shown_now = 1'b1;
        end else begin
            check_value("pred_valid_o", 32'(pred_valid_o), 32'd0);
        end
    endtask

    initial begin
        step_t st;
        int    pos;
        pon_rst_n_i = 1'b0;
        req_valid_i = 1'b0;
        req_pc_i = '0;
        res_valid_i = 1'b0;
        res_i = '0;
        rng = 32'd35858;
        credits = bp_pkg::QUEUE_DEPTH;
        last_res_cyc = -10;
        last_res = 1'b0;
        exp_correct = 1'b0;
        for (int i = 0; i < bp_pkg::TABLE_DEPTH; i++) begin
            m_cnt[i] = bp_pkg::CNT_RESET;
            m_tgt[i] = '0;
        end
        build_directed();
        build_random(170);
        limit = 4 * steps.size() + 50;
        repeat (4) @(negedge clk);
        pon_rst_n_i = 1'b1;
        pos = 0;
        while (pos < steps.size() || pend_q.size() > 0 || last_res) begin
            @(negedge clk);
            check_outputs();
            req_valid_i = 1'b0;
            res_valid_i = 1'b0;
            last_res = 1'b0;
            if (pos < steps.size()) begin
                st = steps[pos];
                case (st.kind)
                    K_REQ: begin
                        // Needs a credit and the table write of any earlier outcome
                        if (credits > 0 && cycles >= last_res_cyc + 2) begin
                            issue_request(st.pc);
                            pos++;
                        end
                    end
                    K_RES: begin
                        if (res_q.size() > 0) begin
                            apply_outcome(st.taken, st.target);
                            pos++;
                        end
                    end
                    default: begin
                        check_credits(int'(st.credits));
                        pos++;
                    end
                endcase
            end
            // A prediction may be resolved from the next cycle on
            if (shown_now) begin
                res_q.push_back(shown_pred);
            end
        end
        $display("** PASS **");
        $finish;
    end

endmodule

/* verilog.f */
logic/bp_pkg.sv
logic/bp_pred_table.sv
logic/bp_lookup_stage.sv
logic/bp_outcome_queue.sv
logic/bp_resolve_stage.sv
logic/bp_top.sv
tests/bp_tb.sv
